// ==== verilog/cp0_defs.svh ====
`ifndef CP0_DEFS_SVH
`define CP0_DEFS_SVH

// --------------------
// Datapath width
`define CP0_XLEN            32                  // Data and address width

// --------------------
// Exception vector
`define CP0_VECTOR_BASE     32'h8000_0000       // kseg0, non-boot base
`define CP0_VECTOR_OFFSET   32'h0000_0180       // General exception offset
`define CP0_VECTOR_GENERAL  (`CP0_VECTOR_BASE + `CP0_VECTOR_OFFSET)

`define CP0_STATUS_RESET    32'h0000_0000       // Kernel mode, interrupts off
`define CP0_COUNT_RESET     32'h0000_0000       // Count and Compare start value

`endif

// ==== verilog/cp0_arch_pkg.sv ====
package cp0_arch_pkg;

    // --------------------
    // Register numbers (select 0 only)
    typedef enum logic [4:0] {
        REG_BADVADDR = 5'd8,
        REG_COUNT    = 5'd9,
        REG_COMPARE  = 5'd11,
        REG_STATUS   = 5'd12,
        REG_CAUSE    = 5'd13,
        REG_EPC      = 5'd14
    } reg_addr_e;

    // --------------------
    // Cause.ExcCode values
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,                    // Interrupt
        EXC_ADEL = 5'd4,                    // Address error, load or fetch
        EXC_ADES = 5'd5,                    // Address error, store
        EXC_IBE  = 5'd6,                    // Instruction bus error
        EXC_DBE  = 5'd7,                    // Data bus error
        EXC_SYS  = 5'd8,                    // Syscall
        EXC_BP   = 5'd9,                    // Breakpoint
        EXC_RI   = 5'd10,                   // Reserved instruction
        EXC_CPU  = 5'd11,                   // Coprocessor unusable
        EXC_OV   = 5'd12,                   // Arithmetic overflow
        EXC_TR   = 5'd13                    // Trap
    } exc_code_e;

    // Field positions in the Status and Cause words
    localparam int STATUS_IE     = 0;
    localparam int STATUS_EXL    = 1;
    localparam int STATUS_KSU_LO = 3;       // KSU is [4:3]
    localparam int STATUS_IM_LO  = 8;       // IM is [15:8]
    localparam int CAUSE_IP_LO   = 8;       // IP is [15:8]

    localparam logic [1:0] KSU_USER = 2'b10;

    // Status as seen by the exception logic
    typedef struct packed {
        logic       ie;                     // Global interrupt enable
        logic       exl;                    // Exception level
        logic       kernel;                 // Effective kernel mode
        logic [7:0] im;                     // Interrupt mask
        logic [7:0] ip;                     // Pending interrupts
    } status_view_t;

endpackage

// ==== verilog/cp0_pipe_pkg.sv ====
`include "cp0_defs.svh"

package cp0_pipe_pkg;

    // Stage index into stall/flush vectors
    localparam int STAGE_IF  = 0;
    localparam int STAGE_ID  = 1;
    localparam int STAGE_EX  = 2;
    localparam int STAGE_MEM = 3;

    typedef struct packed {
        logic [`CP0_XLEN-1:0] pc;           // Fetch address for IF
        logic                 is_bds;       // Instruction sits in a delay slot
        logic                 source;       // Stage may still fault
    } stage_info_t;

    // Raw fault flags from the pipeline
    typedef struct packed {
        logic addr_if;                      // IF
        logic ibus;                         // IF
        logic syscall;                      // ID
        logic breakpoint;                   // ID
        logic reserved;                     // ID
        logic overflow;                     // EX
        logic addr_load;                    // MEM
        logic addr_store;                   // MEM
        logic dbus;                         // MEM
        logic trap;                         // MEM
    } exc_req_t;

    typedef struct packed {
        logic       mfc0;
        logic       mtc0;
        logic       eret;
        logic [4:0] addr;                   // rd field
    } cp0_op_t;

    typedef struct packed {
        logic [3:0] stall;
        logic [3:0] flush;
    } pipe_ctrl_t;

    typedef struct packed {
        logic                    take;           // Accept this cycle
        cp0_arch_pkg::exc_code_e code;
        logic [`CP0_XLEN-1:0]    epc;
        logic                    bd;
        logic [`CP0_XLEN-1:0]    bad_addr;
        logic                    bad_addr_valid;
    } exc_commit_t;

    typedef struct packed {
        logic                 en;           // Already qualified
        logic [4:0]           addr;
        logic [`CP0_XLEN-1:0] data;
    } cp0_write_t;

endpackage

// ==== verilog/cp0_exception_unit.sv ====
`include "cp0_defs.svh"

module cp0_exception_unit (
    input  cp0_pipe_pkg::cp0_op_t      op,
    input  logic [`CP0_XLEN-1:0]       wdata,           // mtc0 source data
    input  logic                       id_stall,
    input  logic                       id_is_flushed,   // ID holds a forced NOP
    input  cp0_pipe_pkg::exc_req_t     exc,
    input  cp0_pipe_pkg::stage_info_t  if_info,
    input  cp0_pipe_pkg::stage_info_t  id_info,
    input  cp0_pipe_pkg::stage_info_t  ex_info,
    input  cp0_pipe_pkg::stage_info_t  mem_info,
    input  logic [`CP0_XLEN-1:0]       bad_addr_mem,
    input  cp0_arch_pkg::status_view_t status,
    input  logic [`CP0_XLEN-1:0]       epc,
    output cp0_pipe_pkg::pipe_ctrl_t   pipe_ctrl,
    output cp0_pipe_pkg::exc_commit_t  commit,
    output cp0_pipe_pkg::cp0_write_t   wr,
    output logic                       exception_ready,
    output logic                       exception_pc_select,
    output logic [`CP0_XLEN-1:0]       pc_exception
);

    logic exc_cpu;
    logic int_ok;
    logic eret_go;
    logic if_exc;
    logic id_exc;
    logic ex_exc;
    logic mem_exc;
    logic if_mask;
    logic id_mask;
    logic ex_mask;
    logic if_rdy;
    logic id_rdy;
    logic ex_rdy;
    logic mem_rdy;

    // --------------------
    // Per-stage faults
    assign exc_cpu = (op.mfc0 | op.mtc0 | op.eret) & ~status.kernel;    // CP0 op from user
    assign int_ok  = status.ie & (|(status.ip & status.im)) & ~status.exl & ~id_is_flushed;
    assign eret_go = op.eret & ~id_stall;

    assign if_exc  = exc.addr_if | exc.ibus;
    assign id_exc  = exc.syscall | exc.breakpoint | exc.reserved | exc_cpu | int_ok;
    assign ex_exc  = exc.overflow;
    assign mem_exc = exc.addr_load | exc.addr_store | exc.dbus | exc.trap;

    // Older stage could still fault
    assign ex_mask = mem_info.source;
    assign id_mask = mem_info.source | ex_info.source;
    assign if_mask = mem_info.source | ex_info.source | id_info.source | int_ok;   // Interrupt wins

    assign mem_rdy = mem_exc;                   // MEM never masked
    assign ex_rdy  = ex_exc & ~ex_mask;
    assign id_rdy  = id_exc & ~id_mask;
    assign if_rdy  = if_exc & ~if_mask;

    // --------------------
    // Stalls wait for a clean pipe, flushes follow an accepted exception
    assign pipe_ctrl.stall[cp0_pipe_pkg::STAGE_MEM] = 1'b0;
    assign pipe_ctrl.stall[cp0_pipe_pkg::STAGE_EX]  = ex_exc & ex_mask & ~mem_exc;
    assign pipe_ctrl.stall[cp0_pipe_pkg::STAGE_ID]  = (id_exc | op.eret | op.mtc0) & id_mask
                                                      & ~(mem_exc | ex_exc);
    assign pipe_ctrl.stall[cp0_pipe_pkg::STAGE_IF]  = if_exc & if_mask & ~eret_go
                                                      & ~(mem_exc | ex_exc | id_exc);

    assign pipe_ctrl.flush[cp0_pipe_pkg::STAGE_MEM] = mem_rdy;
    assign pipe_ctrl.flush[cp0_pipe_pkg::STAGE_EX]  = mem_rdy | ex_rdy;
    assign pipe_ctrl.flush[cp0_pipe_pkg::STAGE_ID]  = mem_rdy | ex_rdy | id_rdy;
    assign pipe_ctrl.flush[cp0_pipe_pkg::STAGE_IF]  = mem_rdy | ex_rdy | id_rdy | if_rdy
                                                      | eret_go;   // Slot after eret dropped

    assign exception_ready     = mem_rdy | ex_rdy | id_rdy | if_rdy;
    assign exception_pc_select = exception_ready | eret_go;
    assign pc_exception        = eret_go ? epc : `CP0_VECTOR_GENERAL;

    // --------------------
    // Oldest ready stage fills the commit
    always_comb begin
        commit      = '0;
        commit.take = exception_ready;
        commit.code = cp0_arch_pkg::EXC_INT;
        if (mem_rdy) begin
            commit.epc            = mem_info.pc;
            commit.bd             = mem_info.is_bds;
            commit.bad_addr       = bad_addr_mem;
            commit.bad_addr_valid = 1'b1;
            if (exc.addr_load) begin
                commit.code = cp0_arch_pkg::EXC_ADEL;
            end else if (exc.addr_store) begin
                commit.code = cp0_arch_pkg::EXC_ADES;
            end else if (exc.dbus) begin
                commit.code = cp0_arch_pkg::EXC_DBE;
            end else begin
                commit.code = cp0_arch_pkg::EXC_TR;
            end
        end else if (ex_rdy) begin
            commit.epc  = ex_info.pc;
            commit.bd   = ex_info.is_bds;
            commit.code = cp0_arch_pkg::EXC_OV;
        end else if (id_rdy) begin
            commit.epc = id_info.pc;
            commit.bd  = id_info.is_bds;
            if (exc.syscall) begin
                commit.code = cp0_arch_pkg::EXC_SYS;
            end else if (exc.breakpoint) begin
                commit.code = cp0_arch_pkg::EXC_BP;
            end else if (exc.reserved) begin
                commit.code = cp0_arch_pkg::EXC_RI;
            end else if (exc_cpu) begin
                commit.code = cp0_arch_pkg::EXC_CPU;
            end                                             // Else interrupt, code 0
        end else if (if_rdy) begin
            commit.epc            = if_info.pc;             // Faulting fetch address
            commit.bd             = if_info.is_bds;
            commit.bad_addr       = if_info.pc;
            commit.bad_addr_valid = 1'b1;
            commit.code = exc.addr_if ? cp0_arch_pkg::EXC_ADEL : cp0_arch_pkg::EXC_IBE;
        end
    end

    // mtc0 only from kernel, not stalled, no fault anywhere
    assign wr.en   = op.mtc0 & status.kernel & ~id_stall
                     & ~(mem_exc | ex_exc | id_exc | if_exc);
    assign wr.addr = op.addr;
    assign wr.data = wdata;

endmodule

// ==== verilog/cp0_registers.sv ====
`include "cp0_defs.svh"

module cp0_registers (
    input  logic                       clk,
    input  logic                       rst,
    input  cp0_pipe_pkg::cp0_op_t      op,
    input  logic                       id_stall,
    input  cp0_pipe_pkg::exc_commit_t  commit,
    input  cp0_pipe_pkg::cp0_write_t   wr,
    input  logic [4:0]                 interrupts,      // External lines
    input  logic [`CP0_XLEN-1:0]       count,
    input  logic [`CP0_XLEN-1:0]       compare,
    input  logic                       timer_pending,
    output cp0_arch_pkg::status_view_t status,
    output logic [`CP0_XLEN-1:0]       epc,
    output logic                       kernel_mode,
    output logic [`CP0_XLEN-1:0]       rdata
);

    localparam logic [`CP0_XLEN-1:0] STATUS_INIT = `CP0_STATUS_RESET;

    logic [1:0]              ksu;
    logic                    exl;
    logic                    ie;
    logic [7:0]              im;
    logic                    bd;
    logic [1:0]              ip_sw;             // Software interrupts
    logic [4:0]              ip_hw;             // Sampled external lines
    cp0_arch_pkg::exc_code_e exc_code;
    logic [`CP0_XLEN-1:0]    bad_vaddr;
    logic [7:0]              ip;
    logic [`CP0_XLEN-1:0]    status_word;
    logic [`CP0_XLEN-1:0]    cause_word;
    logic                    status_wr;
    logic                    cause_wr;

    assign status_wr = wr.en & (wr.addr == cp0_arch_pkg::REG_STATUS);
    assign cause_wr  = wr.en & (wr.addr == cp0_arch_pkg::REG_CAUSE);

    // --------------------
    // Status and Cause control fields
    always_ff @(posedge clk) begin
        if (rst) begin
            ksu      <= STATUS_INIT[cp0_arch_pkg::STATUS_KSU_LO +: 2];
            exl      <= STATUS_INIT[cp0_arch_pkg::STATUS_EXL];
            ie       <= STATUS_INIT[cp0_arch_pkg::STATUS_IE];
            im       <= STATUS_INIT[cp0_arch_pkg::STATUS_IM_LO +: 8];
            bd       <= 1'b0;
            ip_sw    <= 2'b00;
            ip_hw    <= 5'b0;
            exc_code <= cp0_arch_pkg::EXC_INT;
        end else begin
            ip_hw <= interrupts;                    // IP[6:2] lag one cycle
            if (commit.take) begin
                exl      <= 1'b1;
                exc_code <= commit.code;
                if (!exl) begin
                    bd <= commit.bd;                // Nested fault keeps first BD
                end
            end else begin
                if (status_wr) begin
                    ksu <= wr.data[cp0_arch_pkg::STATUS_KSU_LO +: 2];
                    exl <= wr.data[cp0_arch_pkg::STATUS_EXL];
                    ie  <= wr.data[cp0_arch_pkg::STATUS_IE];
                    im  <= wr.data[cp0_arch_pkg::STATUS_IM_LO +: 8];
                end else if (op.eret && !id_stall) begin
                    exl <= 1'b0;                    // Return from handler
                end
                if (cause_wr) begin
                    ip_sw <= wr.data[cp0_arch_pkg::CAUSE_IP_LO +: 2];
                end
            end
        end
    end

    // EPC and BadVAddr
    always_ff @(posedge clk) begin
        if (commit.take) begin
            if (!exl) begin
                epc <= commit.epc;
            end
            if (commit.bad_addr_valid) begin
                bad_vaddr <= commit.bad_addr;
            end
        end else if (wr.en && wr.addr == cp0_arch_pkg::REG_EPC) begin
            epc <= wr.data;
        end
    end

    // --------------------
    // Architectural views
    assign ip          = {timer_pending, ip_hw, ip_sw};     // IP7 is the timer
    assign kernel_mode = (ksu != cp0_arch_pkg::KSU_USER) | exl;

    assign status_word = {16'b0, im, 3'b0, ksu, 1'b0, exl, ie};
    assign cause_word  = {bd, 15'b0, ip, 1'b0, exc_code, 2'b00};

    assign status.ie     = ie;
    assign status.exl    = exl;
    assign status.kernel = kernel_mode;
    assign status.im     = im;
    assign status.ip     = ip;

    // mfc0 read mux, zero outside kernel
    always_comb begin
        rdata = '0;
        if (op.mfc0 && kernel_mode) begin
            case (op.addr)
                cp0_arch_pkg::REG_BADVADDR: rdata = bad_vaddr;
                cp0_arch_pkg::REG_COUNT:    rdata = count;
                cp0_arch_pkg::REG_COMPARE:  rdata = compare;
                cp0_arch_pkg::REG_STATUS:   rdata = status_word;
                cp0_arch_pkg::REG_CAUSE:    rdata = cause_word;
                cp0_arch_pkg::REG_EPC:      rdata = epc;
                default:                    rdata = '0;
            endcase
        end
    end

endmodule

// ==== verilog/cp0_timer.sv ====
`include "cp0_defs.svh"

module cp0_timer (
    input  logic                     clk,
    input  logic                     rst,
    input  cp0_pipe_pkg::cp0_write_t wr,
    input  logic                     im7,              // Timer interrupt mask
    output logic [`CP0_XLEN-1:0]     count,
    output logic [`CP0_XLEN-1:0]     compare,
    output logic                     timer_pending     // Drives Cause.IP[7]
);

    logic count_wr;
    logic compare_wr;

    assign count_wr   = wr.en & (wr.addr == cp0_arch_pkg::REG_COUNT);
    assign compare_wr = wr.en & (wr.addr == cp0_arch_pkg::REG_COMPARE);

    always_ff @(posedge clk) begin
        if (rst) begin
            count         <= `CP0_COUNT_RESET;
            compare       <= `CP0_COUNT_RESET;
            timer_pending <= 1'b0;
        end else begin
            count <= count_wr ? wr.data : count + 1'b1;     // Free running
            if (compare_wr) begin
                compare       <= wr.data;
                timer_pending <= 1'b0;                      // Ack by Compare write
            end else if (count == compare && im7) begin
                timer_pending <= 1'b1;                      // Sticky
            end
        end
    end

endmodule

// ==== verilog/cp0_top.sv ====
`include "cp0_defs.svh"

module cp0_top (
    input  logic                      clk,
    input  logic                      rst,
    input  cp0_pipe_pkg::cp0_op_t     op,
    input  logic [`CP0_XLEN-1:0]      wdata,
    input  logic                      id_stall,
    input  logic                      id_is_flushed,
    input  logic [4:0]                interrupts,
    input  cp0_pipe_pkg::exc_req_t    exc,
    input  cp0_pipe_pkg::stage_info_t if_info,
    input  cp0_pipe_pkg::stage_info_t id_info,
    input  cp0_pipe_pkg::stage_info_t ex_info,
    input  cp0_pipe_pkg::stage_info_t mem_info,
    input  logic [`CP0_XLEN-1:0]      bad_addr_mem,
    output logic [`CP0_XLEN-1:0]      rdata,
    output logic                      kernel_mode,
    output cp0_pipe_pkg::pipe_ctrl_t  pipe_ctrl,
    output logic                      exception_ready,
    output logic                      exception_pc_select,
    output logic [`CP0_XLEN-1:0]      pc_exception
);

    cp0_pipe_pkg::exc_commit_t  commit;         // Exception unit to registers
    cp0_pipe_pkg::cp0_write_t   wr;             // Qualified mtc0
    cp0_arch_pkg::status_view_t status;
    logic [`CP0_XLEN-1:0]       epc;            // eret target
    logic [`CP0_XLEN-1:0]       count;
    logic [`CP0_XLEN-1:0]       compare;
    logic                       timer_pending;

    cp0_exception_unit exception_i (
        .op(op), .wdata(wdata), .id_stall(id_stall), .id_is_flushed(id_is_flushed),
        .exc(exc), .if_info(if_info), .id_info(id_info), .ex_info(ex_info),
        .mem_info(mem_info), .bad_addr_mem(bad_addr_mem), .status(status), .epc(epc),
        .pipe_ctrl(pipe_ctrl), .commit(commit), .wr(wr),
        .exception_ready(exception_ready), .exception_pc_select(exception_pc_select),
        .pc_exception(pc_exception)
    );

    cp0_registers registers_i (
        .clk(clk), .rst(rst), .op(op), .id_stall(id_stall), .commit(commit), .wr(wr),
        .interrupts(interrupts), .count(count), .compare(compare),
        .timer_pending(timer_pending), .status(status), .epc(epc),
        .kernel_mode(kernel_mode), .rdata(rdata)
    );

    cp0_timer timer_i (
        .clk(clk), .rst(rst), .wr(wr), .im7(status.im[7]),    // IM7 gates the timer
        .count(count), .compare(compare), .timer_pending(timer_pending)
    );

endmodule

// ==== verification/cp0_properties.sv ====
`include "cp0_defs.svh"

module cp0_properties (
    input logic                     clk,
    input logic                     rst,
    input cp0_pipe_pkg::cp0_op_t    op,
    input cp0_pipe_pkg::pipe_ctrl_t pipe_ctrl,
    input cp0_pipe_pkg::exc_req_t   exc,
    input logic                     exception_ready,
    input logic                     exception_pc_select,
    input logic [`CP0_XLEN-1:0]     pc_exception
);

    logic mem_exc;

    assign mem_exc = exc.addr_load | exc.addr_store | exc.dbus | exc.trap;   // Any MEM fault

    // A stage is held or cleared, never both
    stall_flush_exclusive: assert property (
        @(posedge clk) disable iff (rst) (pipe_ctrl.stall & pipe_ctrl.flush) == 4'b0000
    ) else $error("stall and flush set for the same stage");

    // Accepted exception redirects the PC to the general vector
    ready_selects_pc: assert property (
        @(posedge clk) disable iff (rst)
            (exception_ready && !op.eret) |->
                (exception_pc_select && pc_exception == `CP0_VECTOR_GENERAL)
    ) else $error("exception_ready without a jump to the general vector");

    // Oldest stage clears the whole pipe
    mem_flushes_all: assert property (
        @(posedge clk) disable iff (rst) mem_exc |-> (pipe_ctrl.flush == 4'b1111)
    ) else $error("MEM exception did not flush every stage");

endmodule

bind cp0_top cp0_properties props_i (
    .clk(clk), .rst(rst), .op(op), .pipe_ctrl(pipe_ctrl), .exc(exc),
    .exception_ready(exception_ready), .exception_pc_select(exception_pc_select),
    .pc_exception(pc_exception)
);

// ==== verification/cp0_tb.sv ====
`include "cp0_defs.svh"

module cp0_tb;

    localparam int PERIOD       = 100;
    localparam int SAMPLE_DELAY = PERIOD / 4;       // Outputs settled, well before posedge
    localparam int TEST_CYCLES  = 70;               // Reset plus all tests, timer wait included
    localparam int MARGIN       = 30;
    localparam int TIMER_WAIT   = 20;
    localparam logic [31:0] GENERAL_VECTOR = 32'h8000_0180;
    localparam int SEL_RDATA    = 0;
    localparam int SEL_READY    = 1;
    localparam int SEL_PC       = 2;
    localparam int SEL_CTRL     = 3;                // {stall, flush}
    localparam int SEL_KERNEL   = 4;
    localparam int SEL_PC_SEL   = 5;

    logic                      clk;
    logic                      rst;
    cp0_pipe_pkg::cp0_op_t     op;
    logic [`CP0_XLEN-1:0]      wdata;
    logic                      id_stall;
    logic                      id_is_flushed;
    logic [4:0]                interrupts;
    cp0_pipe_pkg::exc_req_t    exc;
    cp0_pipe_pkg::stage_info_t if_info;
    cp0_pipe_pkg::stage_info_t id_info;
    cp0_pipe_pkg::stage_info_t ex_info;
    cp0_pipe_pkg::stage_info_t mem_info;
    logic [`CP0_XLEN-1:0]      bad_addr_mem;
    logic [`CP0_XLEN-1:0]      rdata;
    logic                      kernel_mode;
    cp0_pipe_pkg::pipe_ctrl_t  pipe_ctrl;
    logic                      exception_ready;
    logic                      exception_pc_select;
    logic [`CP0_XLEN-1:0]      pc_exception;

    // --------------------
    // Reference model state
    logic [1:0]  m_ksu;
    logic        m_exl;
    logic        m_ie;
    logic [7:0]  m_im;
    logic        m_ip7;                             // Timer pending
    logic [4:0]  m_code;
    logic [31:0] m_epc;
    logic [31:0] m_compare;
    logic [31:0] m_badvaddr;

    integer      seed;
    int          errors;
    int          checks;
    string       name_q[$];                         // Pending checks for this cycle
    int          sel_q[$];
    logic [31:0] exp_q[$];

    cp0_top dut_i (
        .clk(clk), .rst(rst), .op(op), .wdata(wdata), .id_stall(id_stall),
        .id_is_flushed(id_is_flushed), .interrupts(interrupts), .exc(exc),
        .if_info(if_info), .id_info(id_info), .ex_info(ex_info), .mem_info(mem_info),
        .bad_addr_mem(bad_addr_mem), .rdata(rdata), .kernel_mode(kernel_mode),
        .pipe_ctrl(pipe_ctrl), .exception_ready(exception_ready),
        .exception_pc_select(exception_pc_select), .pc_exception(pc_exception)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // Expected rdata, pc and mode from the model
    function automatic logic [31:0] ref_value(input int sel, input logic [4:0] addr,
                                              input logic eret_go);
        logic [31:0] value;
        value = '0;
        case (sel)
            SEL_RDATA: begin
                case (addr)
                    cp0_arch_pkg::REG_BADVADDR: value = m_badvaddr;
                    cp0_arch_pkg::REG_COMPARE:  value = m_compare;
                    cp0_arch_pkg::REG_STATUS: begin
                        value = {16'b0, m_im, 3'b0, m_ksu, 1'b0, m_exl, m_ie};
                    end
                    cp0_arch_pkg::REG_CAUSE:    value = {16'b0, m_ip7, 7'b0, 1'b0, m_code, 2'b00};
                    cp0_arch_pkg::REG_EPC:      value = m_epc;
                    default:                    value = '0;
                endcase
                if (m_ksu == 2'b10 && !m_exl) begin
                    value = '0;                     // User mode reads zero
                end
            end
            SEL_PC:     value = eret_go ? m_epc : GENERAL_VECTOR;
            SEL_KERNEL: value = {31'b0, (m_ksu != 2'b10) || m_exl};
            default:    value = '0;
        endcase
        return value;
    endfunction

    function automatic logic [31:0] dut_output(input int sel);
        case (sel)
            SEL_RDATA:  return rdata;
            SEL_READY:  return {31'b0, exception_ready};
            SEL_PC:     return pc_exception;
            SEL_CTRL:   return {24'b0, pipe_ctrl};
            SEL_PC_SEL: return {31'b0, exception_pc_select};
            default:    return {31'b0, kernel_mode};
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic expect_value(input string name, input int sel, input logic [31:0] value);
        name_q.push_back(name);
        sel_q.push_back(sel);
        exp_q.push_back(value);
    endtask

    task automatic clear_inputs();
        op            = '0;
        wdata         = '0;
        id_stall      = 1'b0;
        id_is_flushed = 1'b0;
        interrupts    = 5'b0;
        exc           = '0;
        if_info       = '0;
        id_info       = '0;
        ex_info       = '0;
        mem_info      = '0;
        bad_addr_mem  = '0;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        clear_inputs();                             // Idle pipe unless a test says otherwise
    endtask

    // Accepted exception as the model sees it
    task automatic model_take(input logic [4:0] code, input logic [31:0] pc,
                              input logic [31:0] bad, input logic bad_valid);
        if (!m_exl) begin
            m_epc = pc;                             // Nested fault keeps first EPC
        end
        m_exl  = 1'b1;
        m_code = code;
        if (bad_valid) begin
            m_badvaddr = bad;
        end
    endtask

    // Kernel-mode mtc0
    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        next_cycle();
        op.mtc0 = 1'b1;
        op.addr = addr;
        wdata   = data;
        expect_value("mtc0 raises no exception", SEL_READY, 32'd0);
        case (addr)
            cp0_arch_pkg::REG_EPC: m_epc = data;
            cp0_arch_pkg::REG_COMPARE: begin
                m_compare = data;
                m_ip7     = 1'b0;                   // Compare write acks the timer
            end
            cp0_arch_pkg::REG_STATUS: begin
                m_ksu = data[4:3];
                m_exl = data[1];
                m_ie  = data[0];
                m_im  = data[15:8];
            end
            default: ;
        endcase
    endtask

    task automatic read_reg(input string name, input logic [4:0] addr);
        next_cycle();
        op.mfc0 = 1'b1;
        op.addr = addr;
        expect_value(name, SEL_RDATA, ref_value(SEL_RDATA, addr, 1'b0));
    endtask

    task automatic do_eret(input string name);
        next_cycle();
        op.eret = 1'b1;
        expect_value(name, SEL_PC, ref_value(SEL_PC, 5'd0, 1'b1));
        expect_value({name, " pc select"}, SEL_PC_SEL, 32'd1);
        expect_value({name, " flush"}, SEL_CTRL, 32'h01);   // Only IF dropped
        m_exl = 1'b0;
    endtask

    // --------------------
    // Compare process, runs mid low phase
    initial begin : compare_proc
        forever begin
            @(negedge clk);
            #(SAMPLE_DELAY);
            while (sel_q.size() > 0) begin
                compare_value(name_q.pop_front(), exp_q.pop_front(),
                              dut_output(sel_q.pop_front()));
            end
        end
    end

    initial begin : watchdog
        #((TEST_CYCLES + MARGIN) * PERIOD);
        $display("watchdog expired, run did not finish in %0d cycles", TEST_CYCLES + MARGIN);
        $display("TEST FAILED");
        $finish;
    end

    // --------------------
    // Stimulus
    initial begin : stimulus
        logic [31:0] data;
        logic [31:0] pc;
        logic [31:0] bad;
        logic        seen;
        int          wait_cycles;
        seed   = 18443;
        errors = 0;
        checks = 0;
        rst    = 1'b1;
        clear_inputs();
        m_ksu = 2'b00;
        m_exl = 1'b0;
        m_ie  = 1'b0;
        m_im  = 8'h00;
        m_ip7 = 1'b0;
        m_code = 5'd0;
        m_epc = '0;
        m_compare = '0;
        m_badvaddr = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // Register round trip, Status kept in kernel with IE off
        data = $random(seed);
        write_reg(cp0_arch_pkg::REG_EPC, data);
        read_reg("epc round trip", cp0_arch_pkg::REG_EPC);
        data = $random(seed);
        write_reg(cp0_arch_pkg::REG_COMPARE, data);
        read_reg("compare round trip", cp0_arch_pkg::REG_COMPARE);
        data = $random(seed) & ~32'h0000_0019;
        write_reg(cp0_arch_pkg::REG_STATUS, data);
        read_reg("status round trip", cp0_arch_pkg::REG_STATUS);
        write_reg(cp0_arch_pkg::REG_STATUS, 32'h0);

        // MEM fault beats EX and ID
        pc  = $random(seed) & ~32'h3;
        bad = $random(seed);
        next_cycle();
        exc.dbus        = 1'b1;
        exc.overflow    = 1'b1;
        exc.syscall     = 1'b1;
        mem_info.pc     = pc;
        mem_info.source = 1'b1;
        ex_info.pc      = pc + 32'd4;
        ex_info.source  = 1'b1;
        id_info.pc      = pc + 32'd8;
        id_info.source  = 1'b1;
        bad_addr_mem    = bad;
        expect_value("mem priority ready", SEL_READY, 32'd1);
        expect_value("mem priority pc select", SEL_PC_SEL, 32'd1);
        expect_value("mem priority flush", SEL_CTRL, 32'h0F);
        expect_value("mem priority vector", SEL_PC, ref_value(SEL_PC, 5'd0, 1'b0));
        model_take(cp0_arch_pkg::EXC_DBE, pc, bad, 1'b1);
        read_reg("mem priority cause", cp0_arch_pkg::REG_CAUSE);
        read_reg("mem priority epc", cp0_arch_pkg::REG_EPC);
        read_reg("mem priority badvaddr", cp0_arch_pkg::REG_BADVADDR);

        do_eret("eret pc");
        read_reg("status after eret", cp0_arch_pkg::REG_STATUS);

        // Syscall held while EX may still fault
        pc = $random(seed) & ~32'h3;
        next_cycle();
        exc.syscall    = 1'b1;
        id_info.pc     = pc;
        id_info.source = 1'b1;
        ex_info.source = 1'b1;
        expect_value("masked syscall ready", SEL_READY, 32'd0);
        expect_value("masked syscall pc select", SEL_PC_SEL, 32'd0);
        expect_value("masked syscall stall", SEL_CTRL, 32'h20);
        next_cycle();
        exc.syscall    = 1'b1;
        id_info.pc     = pc;
        id_info.source = 1'b1;
        expect_value("unmasked syscall ready", SEL_READY, 32'd1);
        expect_value("unmasked syscall flush", SEL_CTRL, 32'h03);
        model_take(cp0_arch_pkg::EXC_SYS, pc, 32'h0, 1'b0);
        read_reg("syscall cause", cp0_arch_pkg::REG_CAUSE);
        read_reg("syscall epc", cp0_arch_pkg::REG_EPC);
        do_eret("eret after syscall");

        // Timer interrupt through IM7
        write_reg(cp0_arch_pkg::REG_STATUS, 32'h0000_8001);
        data = $random(seed);
        write_reg(cp0_arch_pkg::REG_COUNT, data);
        write_reg(cp0_arch_pkg::REG_COMPARE, data + 32'd4);
        seen        = 1'b0;
        wait_cycles = 0;
        while (!seen && wait_cycles < TIMER_WAIT) begin
            next_cycle();
            id_info.pc = 32'h0040_1000;
            #(SAMPLE_DELAY);
            seen = exception_ready;
            wait_cycles++;
        end
        if (!seen) begin
            errors++;
            $display("timer interrupt did not arrive within %0d cycles", TIMER_WAIT);
        end else begin
            model_take(cp0_arch_pkg::EXC_INT, 32'h0040_1000, 32'h0, 1'b0);
            m_ip7 = 1'b1;
        end
        read_reg("timer cause", cp0_arch_pkg::REG_CAUSE);
        write_reg(cp0_arch_pkg::REG_COMPARE, data - 32'd100);
        read_reg("timer pending cleared", cp0_arch_pkg::REG_CAUSE);
        do_eret("eret after interrupt");
        write_reg(cp0_arch_pkg::REG_STATUS, 32'h0);

        // mtc0 from user mode
        write_reg(cp0_arch_pkg::REG_STATUS, 32'h0000_0010);
        pc = $random(seed) & ~32'h3;
        next_cycle();
        op.mtc0    = 1'b1;
        op.addr    = cp0_arch_pkg::REG_COMPARE;
        wdata      = $random(seed);
        id_info.pc = pc;
        expect_value("user mode", SEL_KERNEL, ref_value(SEL_KERNEL, 5'd0, 1'b0));
        expect_value("cpu ready", SEL_READY, 32'd1);
        expect_value("cpu flush", SEL_CTRL, 32'h03);
        model_take(cp0_arch_pkg::EXC_CPU, pc, 32'h0, 1'b0);
        read_reg("cpu cause", cp0_arch_pkg::REG_CAUSE);
        read_reg("cpu compare kept", cp0_arch_pkg::REG_COMPARE);

        next_cycle();
        @(negedge clk);                             // Last compare has run
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== cp0.f ====
+incdir+verilog
verilog/cp0_arch_pkg.sv
verilog/cp0_pipe_pkg.sv
verilog/cp0_exception_unit.sv
verilog/cp0_registers.sv
verilog/cp0_timer.sv
verilog/cp0_top.sv
verification/cp0_properties.sv
verification/cp0_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CP0 testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module cp0_tb -f cp0.f -o cp0_sim

status=0
./obj_dir/cp0_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
exit 0
